/* common/mipsPkg.sv */
package mipsPkg;

	// word and field widths
	localparam int DataWidth    = 32;
	localparam int RegAddrWidth = 5;
	localparam int ShamtWidth   = 5;
	localparam int ImmWidth     = 16;
	localparam int OpWidth      = 6;
	localparam int FunctWidth   = 6;
	localparam int JumpWidth    = 26;
	localparam int RegCount     = 2 ** RegAddrWidth;

	// word-addressed data memory
	localparam int DataWords    = 1024;
	localparam int MemAddrWidth = $clog2(DataWords);

	localparam logic [DataWidth-1:0]    StackTop = DataWidth'(DataWords - 1); // top word
	localparam logic [RegAddrWidth-1:0] StackReg = 5'd29; // sp
	localparam logic [RegAddrWidth-1:0] LinkReg  = 5'd31; // ra, written by jal

	// opcodes
	localparam logic [OpWidth-1:0] OpRType = 6'd0;
	localparam logic [OpWidth-1:0] OpJ     = 6'd2;
	localparam logic [OpWidth-1:0] OpJal   = 6'd3;
	localparam logic [OpWidth-1:0] OpBeq   = 6'd4;
	localparam logic [OpWidth-1:0] OpBne   = 6'd5;
	localparam logic [OpWidth-1:0] OpAddi  = 6'd8;
	localparam logic [OpWidth-1:0] OpSlti  = 6'd10;
	localparam logic [OpWidth-1:0] OpAndi  = 6'd12;
	localparam logic [OpWidth-1:0] OpOri   = 6'd13;
	localparam logic [OpWidth-1:0] OpXori  = 6'd14;
	localparam logic [OpWidth-1:0] OpLui   = 6'd15;
	localparam logic [OpWidth-1:0] OpLw    = 6'd35;
	localparam logic [OpWidth-1:0] OpSw    = 6'd43;

	// funct field of R-type
	localparam logic [FunctWidth-1:0] FnSll = 6'd0;
	localparam logic [FunctWidth-1:0] FnSrl = 6'd2;
	localparam logic [FunctWidth-1:0] FnSra = 6'd3;
	localparam logic [FunctWidth-1:0] FnJr  = 6'd8;
	localparam logic [FunctWidth-1:0] FnAdd = 6'd32;
	localparam logic [FunctWidth-1:0] FnSub = 6'd34;
	localparam logic [FunctWidth-1:0] FnAnd = 6'd36;
	localparam logic [FunctWidth-1:0] FnOr  = 6'd37;
	localparam logic [FunctWidth-1:0] FnXor = 6'd38;
	localparam logic [FunctWidth-1:0] FnNor = 6'd39;
	localparam logic [FunctWidth-1:0] FnSlt = 6'd42;

	typedef enum logic [3:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluXor,
		AluNor,
		AluSlt,
		AluSll,
		AluSrl,
		AluSra,
		AluLui
	} aluOpType;

	typedef enum logic [1:0] {
		WbAlu,
		WbMem,
		WbLink
	} wbSelType;

endpackage

/* verilog/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit import mipsPkg::*;
(
	input  logic [DataWidth-1:0]    instr,
	output logic [RegAddrWidth-1:0] rsAddr,
	output logic [RegAddrWidth-1:0] rtAddr,
	output logic [RegAddrWidth-1:0] wbReg,
	output logic [ShamtWidth-1:0]   shamt,
	output logic [DataWidth-1:0]    imm,
	output logic [JumpWidth-1:0]    jumpIndex,
	output aluOpType                aluOp,
	output logic                    aluSrcImm,
	output logic                    regWrite,
	output logic                    memWrite,
	output logic                    branchEq,
	output logic                    branchNe,
	output logic                    jump,
	output logic                    jumpReg,
	output wbSelType                wbSel
);

	logic [OpWidth-1:0]      opcode;
	logic [FunctWidth-1:0]   funct;
	logic [RegAddrWidth-1:0] rdAddr;
	logic                    writeReq; // before the zero-register check

	assign opcode    = instr[31:26];
	assign funct     = instr[FunctWidth-1:0];
	assign rsAddr    = instr[25:21];
	assign rtAddr    = instr[20:16];
	assign rdAddr    = instr[15:11];
	assign shamt     = instr[10:6];
	assign jumpIndex = instr[JumpWidth-1:0];
	assign imm       = {{(DataWidth - ImmWidth){instr[ImmWidth-1]}}, instr[ImmWidth-1:0]};

	always_comb
	begin
		wbReg     = rtAddr; // immediates and loads write rt
		aluOp     = AluAdd;
		aluSrcImm = 1'b1;
		writeReq  = 1'b0;
		memWrite  = 1'b0;
		branchEq  = 1'b0;
		branchNe  = 1'b0;
		jump      = 1'b0;
		jumpReg   = 1'b0;
		wbSel     = WbAlu;
		case (opcode)
			OpRType:
			begin
				wbReg     = rdAddr;
				aluSrcImm = 1'b0;
				writeReq  = 1'b1;
				case (funct)
					FnAdd: aluOp = AluAdd;
					FnSub: aluOp = AluSub;
					FnAnd: aluOp = AluAnd;
					FnOr:  aluOp = AluOr;
					FnXor: aluOp = AluXor;
					FnNor: aluOp = AluNor;
					FnSlt: aluOp = AluSlt;
					FnSll: aluOp = AluSll;
					FnSrl: aluOp = AluSrl;
					FnSra: aluOp = AluSra;
					FnJr:
					begin
						writeReq = 1'b0;
						jumpReg  = 1'b1;
					end
					default: writeReq = 1'b0; // unknown funct is a no-op
				endcase
			end
			OpAddi: writeReq = 1'b1;
			OpSlti:
			begin
				aluOp    = AluSlt;
				writeReq = 1'b1;
			end
			OpAndi:
			begin
				aluOp    = AluAnd;
				writeReq = 1'b1;
			end
			OpOri:
			begin
				aluOp    = AluOr;
				writeReq = 1'b1;
			end
			OpXori:
			begin
				aluOp    = AluXor;
				writeReq = 1'b1;
			end
			OpLui:
			begin
				aluOp    = AluLui;
				writeReq = 1'b1;
			end
			OpLw:
			begin
				writeReq = 1'b1;
				wbSel    = WbMem;
			end
			OpSw: memWrite = 1'b1; // address is rs + imm
			OpBeq:
			begin
				aluSrcImm = 1'b0;
				branchEq  = 1'b1;
			end
			OpBne:
			begin
				aluSrcImm = 1'b0;
				branchNe  = 1'b1;
			end
			OpJ: jump = 1'b1;
			OpJal:
			begin
				jump     = 1'b1;
				writeReq = 1'b1;
				wbReg    = LinkReg;
				wbSel    = WbLink;
			end
			default: ; // unknown opcode retires as a no-op
		endcase
	end

	// register 0 stays zero
	assign regWrite = writeReq && (wbReg != '0);

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps

module registerFile import mipsPkg::*;
(
	input  logic                    Clock,
	input  logic                    reset,
	input  logic [RegAddrWidth-1:0] rsAddr,
	input  logic [RegAddrWidth-1:0] rtAddr,
	input  logic                    writeEnable,
	input  logic [RegAddrWidth-1:0] writeReg,
	input  logic [DataWidth-1:0]    writeData,
	output logic [DataWidth-1:0]    rsData,
	output logic [DataWidth-1:0]    rtData
);

	logic [DataWidth-1:0] regs [RegCount];

	// both read ports are combinational
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];

	always_ff @(posedge Clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= (i == int'(StackReg)) ? StackTop : '0; // sp at top of memory
		end
		else if (writeEnable && writeReg != '0)
			regs[writeReg] <= writeData;
	end

	// decode must already have dropped writes to register 0
	assert property (@(posedge Clock) disable iff (reset) writeEnable |-> writeReg != '0)
		else $error("write enabled for register 0");

endmodule

/* verilog/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit import mipsPkg::*;
(
	input  logic [DataWidth-1:0]  rsData,
	input  logic [DataWidth-1:0]  rtData,
	input  logic [DataWidth-1:0]  imm,
	input  logic [ShamtWidth-1:0] shamt,
	input  logic                  aluSrcImm,
	input  aluOpType              aluOp,
	output logic [DataWidth-1:0]  aluResult,
	output logic                  equal
);

	logic [DataWidth-1:0] operandB;

	assign operandB = aluSrcImm ? imm : rtData;
	assign equal    = (rsData == rtData); // beq and bne always compare registers

	always_comb
	begin
		case (aluOp)
			AluAdd: aluResult = rsData + operandB;
			AluSub: aluResult = rsData - operandB;
			AluAnd: aluResult = rsData & operandB;
			AluOr:  aluResult = rsData | operandB;
			AluXor: aluResult = rsData ^ operandB;
			AluNor: aluResult = ~(rsData | operandB);
			AluSlt: aluResult = DataWidth'($signed(rsData) < $signed(operandB));
			AluSll: aluResult = operandB << shamt;
			AluSrl: aluResult = operandB >> shamt;
			AluSra: aluResult = $signed(operandB) >>> shamt;
			AluLui: aluResult = operandB << ImmWidth; // low half of imm moves up
			default: aluResult = '0;
		endcase

		assert final (aluOp inside {AluAdd, AluSub, AluAnd, AluOr, AluXor, AluNor,
				AluSlt, AluSll, AluSrl, AluSra, AluLui})
			else $error("aluOp outside the known set: %0d", aluOp);
	end

endmodule

/* verilog/branchUnit.sv */
`timescale 1ns/1ps

module branchUnit import mipsPkg::*;
(
	input  logic                 Clock,
	input  logic                 reset,
	input  logic [DataWidth-1:0] imm,
	input  logic [JumpWidth-1:0] jumpIndex,
	input  logic [DataWidth-1:0] rsData,
	input  logic                 equal,
	input  logic                 branchEq,
	input  logic                 branchNe,
	input  logic                 jump,
	input  logic                 jumpReg,
	output logic [DataWidth-1:0] pc,
	output logic [DataWidth-1:0] pcPlus1
);

	logic [DataWidth-1:0] pcNext;
	logic [DataWidth-1:0] branchTarget;
	logic [DataWidth-1:0] jumpTarget;
	logic                 branchTaken;

	assign pcPlus1      = pc + DataWidth'(1); // word addressed
	assign branchTarget = pcPlus1 + imm;
	assign jumpTarget   = {pcPlus1[DataWidth-1:JumpWidth], jumpIndex};
	assign branchTaken  = (branchEq && equal) || (branchNe && !equal);

	always_comb
	begin
		if (jumpReg)
			pcNext = rsData;
		else if (jump)
			pcNext = jumpTarget;
		else if (branchTaken)
			pcNext = branchTarget;
		else
			pcNext = pcPlus1;
	end

	always_ff @(posedge Clock)
	begin
		if (reset)
			pc <= '0;
		else
			pc <= pcNext;
	end

	// j/jal come from the opcode, jr from the funct field
	assert property (@(posedge Clock) disable iff (reset) !(jump && jumpReg))
		else $error("jump and jumpReg decoded together");

endmodule

/* verilog/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage import mipsPkg::*;
(
	input  logic                 Clock,
	input  logic [DataWidth-1:0] aluResult,
	input  logic [DataWidth-1:0] rtData,
	input  logic                 memWrite,
	input  wbSelType             wbSel,
	input  logic [DataWidth-1:0] pcPlus1,
	output logic [DataWidth-1:0] wbData
);

	logic [DataWidth-1:0]    dataMem [DataWords];
	logic [MemAddrWidth-1:0] memAddr;
	logic [DataWidth-1:0]    loadData;

	// upper address bits are ignored, memory wraps
	assign memAddr  = aluResult[MemAddrWidth-1:0];
	assign loadData = dataMem[memAddr];

	always_ff @(posedge Clock)
	begin
		if (memWrite)
			dataMem[memAddr] <= rtData;
	end

	// write-back source
	always_comb
	begin
		case (wbSel)
			WbMem:   wbData = loadData;
			WbLink:  wbData = pcPlus1; // jal return address
			default: wbData = aluResult;
		endcase
	end

endmodule

/* verilog/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*;
(
	input  logic                    Clock,
	input  logic                    reset,
	input  logic [DataWidth-1:0]    instr,
	output logic [DataWidth-1:0]    instrAddr,
	output logic                    wbValid,
	output logic [RegAddrWidth-1:0] wbReg,
	output logic [DataWidth-1:0]    wbData
);

	logic [RegAddrWidth-1:0] rsAddr;
	logic [RegAddrWidth-1:0] rtAddr;
	logic [ShamtWidth-1:0]   shamt;
	logic [DataWidth-1:0]    imm;
	logic [JumpWidth-1:0]    jumpIndex;
	aluOpType                aluOp;
	logic                    aluSrcImm;
	logic                    regWrite;
	logic                    memWrite;
	logic                    memWriteEn;
	logic                    branchEq;
	logic                    branchNe;
	logic                    jump;
	logic                    jumpReg;
	wbSelType                wbSel;
	logic [DataWidth-1:0]    rsData;
	logic [DataWidth-1:0]    rtData;
	logic [DataWidth-1:0]    aluResult;
	logic                    equal;
	logic [DataWidth-1:0]    pc;
	logic [DataWidth-1:0]    pcPlus1;

	assign instrAddr  = pc;
	assign wbValid    = regWrite && !reset; // nothing retires during reset
	assign memWriteEn = memWrite && !reset;

	decodeUnit decodeUnit_inst (
		.instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr), .wbReg(wbReg),
		.shamt(shamt), .imm(imm), .jumpIndex(jumpIndex), .aluOp(aluOp),
		.aluSrcImm(aluSrcImm), .regWrite(regWrite), .memWrite(memWrite),
		.branchEq(branchEq), .branchNe(branchNe), .jump(jump), .jumpReg(jumpReg),
		.wbSel(wbSel)
	);

	registerFile registerFile_inst (
		.Clock(Clock), .reset(reset), .rsAddr(rsAddr), .rtAddr(rtAddr),
		.writeEnable(regWrite), .writeReg(wbReg), .writeData(wbData),
		.rsData(rsData), .rtData(rtData)
	);

	aluUnit aluUnit_inst (
		.rsData(rsData), .rtData(rtData), .imm(imm), .shamt(shamt),
		.aluSrcImm(aluSrcImm), .aluOp(aluOp), .aluResult(aluResult), .equal(equal)
	);

	branchUnit branchUnit_inst (
		.Clock(Clock), .reset(reset), .imm(imm), .jumpIndex(jumpIndex),
		.rsData(rsData), .equal(equal), .branchEq(branchEq), .branchNe(branchNe),
		.jump(jump), .jumpReg(jumpReg), .pc(pc), .pcPlus1(pcPlus1)
	);

	memoryStage memoryStage_inst (
		.Clock(Clock), .aluResult(aluResult), .rtData(rtData), .memWrite(memWriteEn),
		.wbSel(wbSel), .pcPlus1(pcPlus1), .wbData(wbData)
	);

endmodule

/* sim/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb import mipsPkg::*;
();

	localparam int NumInstr       = 2000;
	localparam int ResetCycles    = 16;
	localparam int HalfPeriod     = 20;
	localparam int WatchdogCycles = (NumInstr + ResetCycles) * 11 / 10; // 10 percent margin

	localparam logic [FunctWidth-1:0] AluFuncts [10] = '{FnAdd, FnSub, FnAnd, FnOr, FnXor,
		FnNor, FnSlt, FnSll, FnSrl, FnSra};
	localparam logic [OpWidth-1:0] ImmOps [6] = '{OpAddi, OpSlti, OpAndi, OpOri, OpXori, OpLui};

	logic                    Clock;
	logic                    reset;
	logic [DataWidth-1:0]    instr;
	logic [DataWidth-1:0]    instrAddr;
	logic                    wbValid;
	logic [RegAddrWidth-1:0] wbReg;
	logic [DataWidth-1:0]    wbData;

	// reference model state
	logic [DataWidth-1:0] modelRegs [RegCount];
	logic [DataWidth-1:0] modelMem [DataWords];
	logic                 memWritten [DataWords];
	logic [DataWidth-1:0] modelPc;
	int                   storedAddrs [$]; // words that lw may read back

	// expected outcome of the instruction on instr
	logic [DataWidth-1:0]    rsVal;
	logic [DataWidth-1:0]    rtVal;
	logic [DataWidth-1:0]    immExt;
	logic [DataWidth-1:0]    pcNext1;
	logic [DataWidth-1:0]    memSum;
	logic                    expValid;
	logic [RegAddrWidth-1:0] expReg;
	logic [DataWidth-1:0]    expData;
	logic                    expMemWr;
	logic [MemAddrWidth-1:0] expMemAddr;
	logic [DataWidth-1:0]    expNextPc;

	logic [31:0] rngState;
	int          wbErrors;
	int          pcErrors;
	int          resetErrors;

	mipsCore mipsCore_inst (
		.Clock(Clock), .reset(reset), .instr(instr), .instrAddr(instrAddr),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	always #HalfPeriod Clock = ~Clock;

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] s;
		s = state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sa);
		return {OpRType, rs, rt, rd, sa, fn};
	endfunction

	function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] immVal);
		return {op, rs, rt, immVal};
	endfunction

	function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] index);
		return {op, index};
	endfunction

	always_comb
	begin
		rsVal      = (instr[25:21] == '0) ? '0 : modelRegs[instr[25:21]];
		rtVal      = (instr[20:16] == '0) ? '0 : modelRegs[instr[20:16]];
		immExt     = {{16{instr[15]}}, instr[15:0]};
		pcNext1    = modelPc + 32'd1;
		memSum     = rsVal + immExt;
		expMemAddr = memSum[MemAddrWidth-1:0]; // memory wraps on the low bits
		expValid   = 1'b0;
		expReg     = instr[20:16];
		expData    = '0;
		expMemWr   = 1'b0;
		expNextPc  = pcNext1;
		case (instr[31:26])
			OpRType:
			begin
				expReg   = instr[15:11];
				expValid = 1'b1;
				case (instr[5:0])
					FnAdd: expData = rsVal + rtVal;
					FnSub: expData = rsVal - rtVal;
					FnAnd: expData = rsVal & rtVal;
					FnOr:  expData = rsVal | rtVal;
					FnXor: expData = rsVal ^ rtVal;
					FnNor: expData = ~(rsVal | rtVal);
					FnSlt: expData = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
					FnSll: expData = rtVal << instr[10:6];
					FnSrl: expData = rtVal >> instr[10:6];
					FnSra: expData = $signed(rtVal) >>> instr[10:6];
					FnJr:
					begin
						expValid  = 1'b0;
						expNextPc = rsVal;
					end
					default: expValid = 1'b0;
				endcase
			end
			OpAddi:
			begin
				expValid = 1'b1;
				expData  = rsVal + immExt;
			end
			OpSlti:
			begin
				expValid = 1'b1;
				expData  = ($signed(rsVal) < $signed(immExt)) ? 32'd1 : 32'd0;
			end
			OpAndi:
			begin
				expValid = 1'b1;
				expData  = rsVal & immExt;
			end
			OpOri:
			begin
				expValid = 1'b1;
				expData  = rsVal | immExt;
			end
			OpXori:
			begin
				expValid = 1'b1;
				expData  = rsVal ^ immExt;
			end
			OpLui:
			begin
				expValid = 1'b1;
				expData  = {instr[15:0], 16'h0000};
			end
			OpLw:
			begin
				expValid = 1'b1;
				expData  = modelMem[expMemAddr];
			end
			OpSw: expMemWr = 1'b1;
			OpBeq:
				if (rsVal == rtVal)
					expNextPc = pcNext1 + immExt;
			OpBne:
				if (rsVal != rtVal)
					expNextPc = pcNext1 + immExt;
			OpJ: expNextPc = {pcNext1[31:26], instr[25:0]};
			OpJal:
			begin
				expNextPc = {pcNext1[31:26], instr[25:0]};
				expValid  = 1'b1;
				expReg    = LinkReg;
				expData   = pcNext1; // return address
			end
			default: ;
		endcase
		if (expReg == '0)
			expValid = 1'b0; // register 0 never changes
	end

	// model retires one instruction per edge, like the core
	always @(posedge Clock)
	begin
		if (reset)
		begin
			for (int i = 0; i < RegCount; i++)
				modelRegs[i] <= (i == int'(StackReg)) ? StackTop : '0;
			for (int i = 0; i < DataWords; i++)
				memWritten[i] <= 1'b0;
			storedAddrs.delete();
			modelPc <= '0;
		end
		else
		begin
			if (expValid)
				modelRegs[expReg] <= expData;
			if (expMemWr)
			begin
				modelMem[expMemAddr] <= rtVal;
				if (!memWritten[expMemAddr])
				begin
					memWritten[expMemAddr] <= 1'b1;
					storedAddrs.push_back(int'(expMemAddr));
				end
			end
			modelPc <= expNextPc;
		end
	end

	task automatic drawInstruction(output logic [DataWidth-1:0] word);
		logic [31:0] r;
		logic [31:0] operands;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] immVal;
		logic [6:0]  kind;
		int          pick;
		rngState = xorshift(rngState);
		r        = rngState;
		rngState = xorshift(rngState);
		operands = rngState;
		rs       = operands[4:0];
		rt       = operands[9:5];
		rd       = operands[14:10];
		immVal   = operands[31:16];
		kind     = r[6:0];
		if (kind < 7'd5)
			word = encodeJ(OpJ, operands[25:0]);
		else if (kind < 7'd9)
			word = encodeJ(OpJal, operands[25:0]);
		else if (kind < 7'd13)
			word = encodeR(FnJr, rs, 5'd0, 5'd0, 5'd0); // about one in ten is a jump
		else if (kind < 7'd29)
		begin
			if (r[8])
				rt = rs; // equal operands, so beq is taken
			word = encodeI(r[7] ? OpBne : OpBeq, rs, rt, immVal);
		end
		else if (kind < 7'd61)
			word = encodeR(AluFuncts[r[19:16] % 4'd10], rs, rt, rd, r[24:20]);
		else if (kind < 7'd93)
			word = encodeI(ImmOps[r[18:16] % 3'd6], rs, rt, immVal);
		else if (kind < 7'd111 || storedAddrs.size() == 0)
			word = encodeI(OpSw, rs, rt, immVal);
		else
		begin
			pick = r[31:8] % storedAddrs.size();
			word = encodeI(OpLw, 5'd0, rt, 16'(storedAddrs[pick])); // only stored words
		end
	endtask

	assert property (@(posedge Clock) reset |-> !wbValid)
		else
		begin
			resetErrors++;
			$display("FAILED %0t wbValid expected 0 actual %b", $time, $sampled(wbValid));
		end

	assert property (@(posedge Clock) $fell(reset) |-> instrAddr == '0)
		else
		begin
			resetErrors++;
			$display("FAILED %0t instrAddr expected 0 actual %h", $time, $sampled(instrAddr));
		end

	assert property (@(posedge Clock) disable iff (reset) instrAddr == modelPc)
		else
		begin
			pcErrors++;
			$display("FAILED %0t instrAddr expected %h actual %h", $time,
				$sampled(modelPc), $sampled(instrAddr));
		end

	assert property (@(posedge Clock) disable iff (reset) wbValid == expValid)
		else
		begin
			wbErrors++;
			$display("FAILED %0t wbValid expected %b actual %b", $time,
				$sampled(expValid), $sampled(wbValid));
		end

	assert property (@(posedge Clock) disable iff (reset) expValid |-> wbReg == expReg)
		else
		begin
			wbErrors++;
			$display("FAILED %0t wbReg expected %0d actual %0d", $time,
				$sampled(expReg), $sampled(wbReg));
		end

	assert property (@(posedge Clock) disable iff (reset) expValid |-> wbData == expData)
		else
		begin
			wbErrors++;
			$display("FAILED %0t wbData expected %h actual %h", $time,
				$sampled(expData), $sampled(wbData));
		end

	assert property (@(posedge Clock) disable iff (reset) wbValid |-> wbReg != '0)
		else
		begin
			wbErrors++;
			$display("write-back reported for register 0 at %0t", $time);
		end

	initial
	begin
		Clock       = 1'b0;
		reset       = 1'b1;
		instr       = encodeI(OpAddi, 5'd0, 5'd1, 16'd1); // would write r1 if reset leaked
		rngState    = 32'hbde9_f501;
		wbErrors    = 0;
		pcErrors    = 0;
		resetErrors = 0;
		repeat (ResetCycles) @(posedge Clock);
		#1;
		reset = 1'b0;
		drawInstruction(instr);
		for (int n = 1; n < NumInstr; n++)
		begin
			@(posedge Clock);
			#1;
			drawInstruction(instr);
		end
		@(posedge Clock); // last instruction retires here
		#1;
		$display("errors: write-back %0d, pc %0d, reset %0d", wbErrors, pcErrors, resetErrors);
		if (wbErrors + pcErrors + resetErrors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial
	begin
		#(WatchdogCycles * 2 * HalfPeriod);
		$display("watchdog expired after %0d cycles before the stream finished", WatchdogCycles);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* src.f */
common/mipsPkg.sv
verilog/decodeUnit.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/branchUnit.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
sim/mipsCoreTb.sv

/* Makefile */
SOURCES := $(shell cat src.f)

obj_dir/VmipsCoreTb: src.f $(SOURCES)
	verilator --binary --timing --assert -f src.f --top-module mipsCoreTb -o VmipsCoreTb

run: obj_dir/VmipsCoreTb
	./obj_dir/VmipsCoreTb | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
